//--- Makefile
# Verilator build and run of the rename testbench

VERILATOR ?= verilator
TOP       ?= tb_rename
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/rename_cases.txt
# bundle v0 cat0 rs1_0 rs2_0 rd0 uses0 v1 cat1 rs1_1 rs2_1 rd1 uses1 exp_count
# wb tag | retire | idle | random cycles
idle
retire
bundle 1 0 1 2 3 1 1 1 3 4 5 1 2
bundle 1 2 3 3 3 1 1 3 3 0 3 1 2
bundle 1 0 6 7 0 0 1 1 0 0 2 1 2
bundle 0 0 1 1 1 1 1 0 1 1 1 1 0
wb 9
bundle 1 0 5 6 1 1 0 0 0 0 0 0 1
bundle 1 0 1 1 4 1 1 0 2 2 6 1 1
bundle 1 0 2 2 6 1 0 0 0 0 0 0 0
retire
bundle 1 0 2 2 6 1 1 0 4 4 7 1 1
retire
retire
retire
bundle 1 0 4 4 7 1 1 0 7 0 0 1 2
wb 3
bundle 1 2 7 3 2 1 0 0 0 0 0 0 1
idle
random 400
idle

//--- dv/tb_rename.sv
`default_nettype none

`include "rename_params.svh"

module tb_rename;

    timeunit 1ns;
    timeprecision 1ps;

    import rename_pkg::*;

    localparam int PERIOD = 40;
    localparam int NARG = 13;
    localparam int OP_BUNDLE = 0;
    localparam int OP_WB = 1;
    localparam int OP_RETIRE = 2;
    localparam int OP_IDLE = 3;
    localparam int OP_RANDOM = 4;

    logic                      clock;
    logic                      rst_n;
    logic [`DISP_W-1:0]        in_valid;
    op_cat_e [`DISP_W-1:0]     in_category;
    arch_reg_t [`DISP_W-1:0]   in_rs1;
    arch_reg_t [`DISP_W-1:0]   in_rs2;
    arch_reg_t [`DISP_W-1:0]   in_rd;
    logic [`DISP_W-1:0]        in_uses_rd;
    logic                      wb_valid;
    phys_tag_t                 wb_tag;
    logic                      retire;
    slot_cnt_t                 dispatch_count;
    logic [`DISP_W-1:0]        disp_valid;
    rob_idx_t [`DISP_W-1:0]    disp_rob_idx;
    phys_tag_t [`DISP_W-1:0]   disp_dest_tag;
    phys_tag_t [`DISP_W-1:0]   disp_src1_tag;
    logic [`DISP_W-1:0]        disp_src1_ready;
    phys_tag_t [`DISP_W-1:0]   disp_src2_tag;
    logic [`DISP_W-1:0]        disp_src2_ready;
    op_cat_e [`DISP_W-1:0]     disp_category;
    logic                      retire_valid;
    arch_reg_t                 retire_arch_rd;
    phys_tag_t                 retire_phys_rd;
    phys_tag_t                 retire_prev_tag;
    op_cat_e                   retire_category;

    // Reference model state
    int map_m [`ARCH_REGS];
    bit ready_m [`PHYS_REGS];
    int free_q [$];
    int rob_rd [$];
    int rob_new [$];
    int rob_prev [$];
    int rob_uses [$];
    int rob_cat [$];
    int rob_tail_m;

    // Command codes, with NARG arguments per command in args
    int ops [$];
    int args [$];

    // Stimulus of the current cycle
    int cv [2];
    int ccat [2];
    int crs1 [2];
    int crs2 [2];
    int crd [2];
    int cu [2];
    int cwbv;
    int cwbt;
    int cret;
    int cexp;

    int     errors;
    int     checks;
    int     watchdog_cycles;
    integer seed;

    rename_top i_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_category     (in_category),
        .in_rs1          (in_rs1),
        .in_rs2          (in_rs2),
        .in_rd           (in_rd),
        .in_uses_rd      (in_uses_rd),
        .wb_valid        (wb_valid),
        .wb_tag          (wb_tag),
        .retire          (retire),
        .dispatch_count  (dispatch_count),
        .disp_valid      (disp_valid),
        .disp_rob_idx    (disp_rob_idx),
        .disp_dest_tag   (disp_dest_tag),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_ready (disp_src1_ready),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_ready (disp_src2_ready),
        .disp_category   (disp_category),
        .retire_valid    (retire_valid),
        .retire_arch_rd  (retire_arch_rd),
        .retire_phys_rd  (retire_phys_rd),
        .retire_prev_tag (retire_prev_tag),
        .retire_category (retire_category)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    task automatic compare(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAILED at %0d ns: %0s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic add_command(input int op, input int a [NARG]);
        ops.push_back(op);
        for (int k = 0; k < NARG; k++) begin
            args.push_back(a[k]);
        end
    endtask

    task automatic load_cases();
        int                 fd;
        int                 r;
        int                 n;
        int                 a [NARG];
        logic [8*16-1:0]    word;
        logic [8*256-1:0]   line;
        fd = $fopen("dv/rename_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file dv/rename_cases.txt");
        end else begin
            while ($fscanf(fd, "%s", word) == 1) begin
                for (int k = 0; k < NARG; k++) begin
                    a[k] = 0;
                end
                if (word == "#") begin
                    r = $fgets(line, fd);
                end else if (word == "bundle") begin
                    for (int k = 0; k < NARG; k++) begin
                        r = $fscanf(fd, "%d", a[k]);
                    end
                    add_command(OP_BUNDLE, a);
                end else if (word == "wb") begin
                    r = $fscanf(fd, "%d", a[0]);
                    add_command(OP_WB, a);
                end else if (word == "retire") begin
                    add_command(OP_RETIRE, a);
                end else if (word == "idle") begin
                    add_command(OP_IDLE, a);
                end else if (word == "random") begin
                    r = $fscanf(fd, "%d", n);
                    // One command per random cycle
                    for (int c = 0; c < n; c++) begin
                        add_command(OP_RANDOM, a);
                    end
                end else begin
                    errors++;
                    $display("Unknown command %0s in the stimulus file", word);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic set_cycle(input int c);
        logic [31:0] r;
        int          b;
        b = c * NARG;
        for (int i = 0; i < 2; i++) begin
            cv[i] = 0;
            ccat[i] = 0;
            crs1[i] = 0;
            crs2[i] = 0;
            crd[i] = 0;
            cu[i] = 0;
        end
        cwbv = 0;
        cwbt = 0;
        cret = 0;
        cexp = -1;
        if (ops[c] == OP_BUNDLE) begin
            for (int i = 0; i < 2; i++) begin
                cv[i] = args[b + 6 * i];
                ccat[i] = args[b + 6 * i + 1];
                crs1[i] = args[b + 6 * i + 2];
                crs2[i] = args[b + 6 * i + 3];
                crd[i] = args[b + 6 * i + 4];
                cu[i] = args[b + 6 * i + 5];
            end
            cexp = args[b + 12];
        end else if (ops[c] == OP_WB) begin
            cwbv = 1;
            cwbt = args[b];
        end else if (ops[c] == OP_RETIRE) begin
            cret = 1;
        end else if (ops[c] == OP_RANDOM) begin
            // One draw fills every field of the cycle
            r = $random(seed);
            for (int i = 0; i < 2; i++) begin
                cv[i] = int'(r[i]);
                ccat[i] = int'(r[2 + 2 * i +: 2]);
                crs1[i] = int'(r[6 + 3 * i +: 3]);
                crs2[i] = int'(r[12 + 3 * i +: 3]);
                crd[i] = int'(r[18 + 3 * i +: 3]);
                cu[i] = int'(r[24 + i]);
            end
            cwbv = int'(r[26]);
            cwbt = int'(r[30:27]);
            cret = int'(r[31]);
        end
    endtask

    task automatic drive_inputs();
        for (int i = 0; i < 2; i++) begin
            in_valid[i] = cv[i][0];
            in_category[i] = op_cat_e'(ccat[i][1:0]);
            in_rs1[i] = arch_reg_t'(crs1[i]);
            in_rs2[i] = arch_reg_t'(crs2[i]);
            in_rd[i] = arch_reg_t'(crd[i]);
            in_uses_rd[i] = cu[i][0];
        end
        wb_valid = cwbv[0];
        wb_tag = phys_tag_t'(cwbt);
        retire = cret[0];
    endtask

    task automatic check_and_update();
        int n;
        int ntag;
        bit stop;
        int rv;
        int dv [2];
        int dt [2];
        int s1t [2];
        int s1r [2];
        int s2t [2];
        int s2r [2];
        int prev [2];
        n = 0;
        ntag = 0;
        stop = 1'b0;
        for (int i = 0; i < 2; i++) begin
            dv[i] = 0;
            dt[i] = 0;
            // Leading valid slots limited by ROB room and free tags
            if (!stop && cv[i] != 0 && n < `ROB_DEPTH - rob_rd.size()
                    && (cu[i] == 0 || ntag < free_q.size())) begin
                dv[i] = 1;
                if (cu[i] != 0) begin
                    dt[i] = free_q[ntag];
                    ntag++;
                end
                n++;
            end else begin
                stop = 1'b1;
            end
            s1t[i] = map_m[crs1[i]];
            s1r[i] = ready_m[s1t[i]];
            s2t[i] = map_m[crs2[i]];
            s2r[i] = ready_m[s2t[i]];
            prev[i] = map_m[crd[i]];
            for (int j = 0; j < i; j++) begin
                if (dv[j] != 0 && cu[j] != 0 && crs1[i] == crd[j]) begin
                    s1t[i] = dt[j];
                    s1r[i] = 0;
                end
                if (dv[j] != 0 && cu[j] != 0 && crs2[i] == crd[j]) begin
                    s2t[i] = dt[j];
                    s2r[i] = 0;
                end
                if (dv[j] != 0 && cu[j] != 0 && crd[i] == crd[j]) begin
                    prev[i] = dt[j];
                end
            end
        end
        compare("dispatch_count", n, int'(dispatch_count));
        if (cexp >= 0) begin
            compare("dispatch_count from cases file", cexp, int'(dispatch_count));
        end
        for (int i = 0; i < 2; i++) begin
            compare($sformatf("disp_valid[%0d]", i), dv[i], int'(disp_valid[i]));
            if (dv[i] != 0) begin
                compare($sformatf("disp_rob_idx[%0d]", i), (rob_tail_m + i) % `ROB_DEPTH,
                        int'(disp_rob_idx[i]));
                compare($sformatf("disp_dest_tag[%0d]", i), dt[i], int'(disp_dest_tag[i]));
                compare($sformatf("disp_src1_tag[%0d]", i), s1t[i], int'(disp_src1_tag[i]));
                compare($sformatf("disp_src1_ready[%0d]", i), s1r[i],
                        int'(disp_src1_ready[i]));
                compare($sformatf("disp_src2_tag[%0d]", i), s2t[i], int'(disp_src2_tag[i]));
                compare($sformatf("disp_src2_ready[%0d]", i), s2r[i],
                        int'(disp_src2_ready[i]));
                compare($sformatf("disp_category[%0d]", i), ccat[i], int'(disp_category[i]));
            end
        end
        rv = (cret != 0 && rob_rd.size() > 0) ? 1 : 0;
        compare("retire_valid", rv, int'(retire_valid));
        if (rv != 0) begin
            compare("retire_arch_rd", rob_rd[0], int'(retire_arch_rd));
            compare("retire_phys_rd", rob_new[0], int'(retire_phys_rd));
            compare("retire_prev_tag", rob_prev[0], int'(retire_prev_tag));
            compare("retire_category", rob_cat[0], int'(retire_category));
        end
        // State update at the coming edge
        // Writeback goes first so that an allocation clears the ready bit
        if (cwbv != 0) begin
            ready_m[cwbt] = 1'b1;
        end
        for (int k = 0; k < ntag; k++) begin
            void'(free_q.pop_front());
        end
        if (rv != 0) begin
            if (rob_uses[0] != 0) begin
                free_q.push_back(rob_prev[0]);
            end
            void'(rob_rd.pop_front());
            void'(rob_new.pop_front());
            void'(rob_prev.pop_front());
            void'(rob_uses.pop_front());
            void'(rob_cat.pop_front());
        end
        for (int i = 0; i < 2; i++) begin
            if (dv[i] != 0) begin
                if (cu[i] != 0) begin
                    map_m[crd[i]] = dt[i];
                    ready_m[dt[i]] = 1'b0;
                end
                rob_rd.push_back(crd[i]);
                rob_new.push_back(dt[i]);
                rob_prev.push_back(prev[i]);
                rob_uses.push_back(cu[i]);
                rob_cat.push_back(ccat[i]);
            end
        end
        rob_tail_m = (rob_tail_m + n) % `ROB_DEPTH;
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = '0;
        in_category = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_rd = '0;
        in_uses_rd = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        retire = 1'b0;
        errors = 0;
        checks = 0;
        watchdog_cycles = 0;
        seed = 32'h4da1_1c6c;
        // Identity map and tags 8 to 15 free after reset
        for (int r = 0; r < `ARCH_REGS; r++) begin
            map_m[r] = r;
        end
        for (int t = 0; t < `PHYS_REGS; t++) begin
            ready_m[t] = 1'b1;
        end
        for (int t = `ARCH_REGS; t < `PHYS_REGS; t++) begin
            free_q.push_back(t);
        end
        rob_tail_m = 0;
        load_cases();
        if (errors == 0) begin
            watchdog_cycles = ops.size() * 50 + 200;
            repeat (10) @(posedge clock);
            #2;
            rst_n = 1'b1;
            for (int c = 0; c < ops.size(); c++) begin
                set_cycle(c);
                drive_inputs();
                #(PERIOD - 4);
                check_and_update();
                @(posedge clock);
                #2;
            end
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of loaded commands
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired, the run did not end within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/dispatch_ctrl.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/reorder_buffer.sv
verilog/rename_top.sv
dv/tb_rename.sv

//--- verilog/dispatch_ctrl.sv
`default_nettype none

`include "rename_params.svh"

module dispatch_ctrl (
    input  wire logic [`DISP_W-1:0]                      in_valid,
    input  wire rename_pkg::op_cat_e [`DISP_W-1:0]       in_category,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0]     in_rs1,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0]     in_rs2,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0]     in_rd,
    input  wire logic [`DISP_W-1:0]                      in_uses_rd,
    input  wire logic [$clog2(`PHYS_REGS+1)-1:0]         free_count,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0]     head_tags,
    input  wire logic [$clog2(`ROB_DEPTH+1)-1:0]         rob_free,
    input  wire rename_pkg::rob_idx_t                    rob_tail,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0]     src1_tag,
    input  wire logic [`DISP_W-1:0]                      src1_ready,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0]     src2_tag,
    input  wire logic [`DISP_W-1:0]                      src2_ready,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0]     rd_tag,
    output rename_pkg::slot_cnt_t                        dispatch_count,
    output rename_pkg::slot_cnt_t                        alloc_count,
    output logic [`DISP_W-1:0]                           map_wr_en,
    output rename_pkg::arch_reg_t [`DISP_W-1:0]          map_wr_addr,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]          map_wr_tag,
    output logic [`DISP_W-1:0]                           rob_alloc_valid,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]          rob_prev_tag,
    output logic [`DISP_W-1:0]                           disp_valid,
    output rename_pkg::rob_idx_t [`DISP_W-1:0]           disp_rob_idx,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]          disp_dest_tag,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]          disp_src1_tag,
    output logic [`DISP_W-1:0]                           disp_src1_ready,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]          disp_src2_tag,
    output logic [`DISP_W-1:0]                           disp_src2_ready,
    output rename_pkg::op_cat_e [`DISP_W-1:0]            disp_category
);

    import rename_pkg::*;

    // Walk slots in order, first blocked slot ends the bundle
    always_comb begin
        slot_cnt_t n_disp;
        slot_cnt_t n_tags;
        logic      stop;
        n_disp = '0;
        n_tags = '0;
        stop = 1'b0;
        disp_valid = '0;
        map_wr_en = '0;
        disp_dest_tag = '0;
        for (int i = 0; i < `DISP_W; i++) begin
            if (!stop && in_valid[i] && (n_disp < rob_free)
                    && (!in_uses_rd[i] || (n_tags < free_count))) begin
                disp_valid[i] = 1'b1;
                if (in_uses_rd[i]) begin
                    // Tags are handed out in slot order
                    disp_dest_tag[i] = head_tags[n_tags];
                    map_wr_en[i] = 1'b1;
                    n_tags = n_tags + 1'b1;
                end
                n_disp = n_disp + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        dispatch_count = n_disp;
        alloc_count = n_tags;
    end

    // Sources and previous tag, with bypass from older slots of the bundle
    always_comb begin
        for (int i = 0; i < `DISP_W; i++) begin
            disp_src1_tag[i] = src1_tag[i];
            disp_src1_ready[i] = src1_ready[i];
            disp_src2_tag[i] = src2_tag[i];
            disp_src2_ready[i] = src2_ready[i];
            rob_prev_tag[i] = rd_tag[i];
            // Youngest older writer wins
            for (int j = 0; j < i; j++) begin
                if (map_wr_en[j] && (in_rs1[i] == in_rd[j])) begin
                    disp_src1_tag[i] = disp_dest_tag[j];
                    disp_src1_ready[i] = 1'b0;
                end
                if (map_wr_en[j] && (in_rs2[i] == in_rd[j])) begin
                    disp_src2_tag[i] = disp_dest_tag[j];
                    disp_src2_ready[i] = 1'b0;
                end
                if (map_wr_en[j] && (in_rd[i] == in_rd[j])) begin
                    rob_prev_tag[i] = disp_dest_tag[j];
                end
            end
            disp_rob_idx[i] = rob_tail + rob_idx_t'(i);
        end
    end

    assign map_wr_addr = in_rd;
    assign map_wr_tag = disp_dest_tag;
    assign rob_alloc_valid = disp_valid;
    assign disp_category = in_category;

endmodule

`default_nettype wire

//--- verilog/free_list.sv
`default_nettype none

`include "rename_params.svh"

module free_list (
    input  wire logic                                clock,
    input  wire logic                                rst_n,
    input  wire rename_pkg::slot_cnt_t               alloc_count,
    input  wire logic                                free_valid,
    input  wire rename_pkg::phys_tag_t               free_tag,
    output logic [$clog2(`PHYS_REGS+1)-1:0]          free_count,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      head_tags
);

    import rename_pkg::*;

    localparam int PTR_W = $clog2(`PHYS_REGS);
    localparam int CNT_W = $clog2(`PHYS_REGS + 1);
    localparam int INIT_FREE = `PHYS_REGS - `ARCH_REGS;

    phys_tag_t        queue_q [`PHYS_REGS];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= PTR_W'(INIT_FREE);
            count_q <= CNT_W'(INIT_FREE);
            // Tags above the architectural range start out free
            for (int i = 0; i < INIT_FREE; i++) begin
                queue_q[i] <= phys_tag_t'(`ARCH_REGS + i);
            end
        end else begin
            head_q <= head_q + PTR_W'(alloc_count);
            if (free_valid) begin
                queue_q[tail_q] <= free_tag;
                tail_q <= tail_q + 1'b1;
            end
            count_q <= count_q - CNT_W'(alloc_count) + CNT_W'(free_valid);
        end
    end

    // Oldest free tags first
    always_comb begin
        for (int i = 0; i < `DISP_W; i++) begin
            head_tags[i] = queue_q[head_q + PTR_W'(i)];
        end
    end

    assign free_count = count_q;

endmodule

`default_nettype wire

//--- verilog/map_table.sv
`default_nettype none

`include "rename_params.svh"

module map_table (
    input  wire logic                                clock,
    input  wire logic                                rst_n,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] rd_addr_a,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] rd_addr_b,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] rd_addr_d,
    input  wire logic [`DISP_W-1:0]                  map_wr_en,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] map_wr_addr,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0] map_wr_tag,
    input  wire logic                                wb_valid,
    input  wire rename_pkg::phys_tag_t               wb_tag,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      tag_a,
    output logic [`DISP_W-1:0]                       ready_a,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      tag_b,
    output logic [`DISP_W-1:0]                       ready_b,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      tag_d
);

    import rename_pkg::*;

    phys_tag_t             map_q [`ARCH_REGS];
    logic [`PHYS_REGS-1:0] ready_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // Identity map, everything ready
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
            ready_q <= '1;
        end else begin
            if (wb_valid) begin
                ready_q[wb_tag] <= 1'b1;
            end
            // Later slot overrides on a shared rd
            for (int i = 0; i < `DISP_W; i++) begin
                if (map_wr_en[i]) begin
                    map_q[map_wr_addr[i]] <= map_wr_tag[i];
                    ready_q[map_wr_tag[i]] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `DISP_W; i++) begin
            tag_a[i] = map_q[rd_addr_a[i]];
            ready_a[i] = ready_q[map_q[rd_addr_a[i]]];
            tag_b[i] = map_q[rd_addr_b[i]];
            ready_b[i] = ready_q[map_q[rd_addr_b[i]]];
            tag_d[i] = map_q[rd_addr_d[i]];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Instructions renamed per bundle
`define DISP_W 2

// Architectural register file size
`define ARCH_REGS 8

// Physical register file size, also the free list depth
`define PHYS_REGS 16

// Reorder buffer entries
`define ROB_DEPTH 8

`endif

//--- verilog/rename_pkg.sv
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // Operation category, carried with each slot
    typedef enum logic [1:0] {
        CAT_ALU,
        CAT_MULT,
        CAT_BRANCH,
        CAT_MEM
    } op_cat_e;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Zero up to a full bundle
    typedef logic [$clog2(`DISP_W+1)-1:0] slot_cnt_t;

endpackage

`default_nettype wire

//--- verilog/rename_top.sv
`default_nettype none

`include "rename_params.svh"

module rename_top (
    input  wire logic                                clock,
    input  wire logic                                rst_n,
    input  wire logic [`DISP_W-1:0]                  in_valid,
    input  wire rename_pkg::op_cat_e [`DISP_W-1:0]   in_category,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] in_rs1,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] in_rs2,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] in_rd,
    input  wire logic [`DISP_W-1:0]                  in_uses_rd,
    input  wire logic                                wb_valid,
    input  wire rename_pkg::phys_tag_t               wb_tag,
    input  wire logic                                retire,
    output rename_pkg::slot_cnt_t                    dispatch_count,
    output logic [`DISP_W-1:0]                       disp_valid,
    output rename_pkg::rob_idx_t [`DISP_W-1:0]       disp_rob_idx,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      disp_dest_tag,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      disp_src1_tag,
    output logic [`DISP_W-1:0]                       disp_src1_ready,
    output rename_pkg::phys_tag_t [`DISP_W-1:0]      disp_src2_tag,
    output logic [`DISP_W-1:0]                       disp_src2_ready,
    output rename_pkg::op_cat_e [`DISP_W-1:0]        disp_category,
    output logic                                     retire_valid,
    output rename_pkg::arch_reg_t                    retire_arch_rd,
    output rename_pkg::phys_tag_t                    retire_phys_rd,
    output rename_pkg::phys_tag_t                    retire_prev_tag,
    output rename_pkg::op_cat_e                      retire_category
);

    import rename_pkg::*;

    // Free list side
    logic [$clog2(`PHYS_REGS+1)-1:0] free_count;
    phys_tag_t [`DISP_W-1:0]         head_tags;
    slot_cnt_t                       alloc_count;
    logic                            free_valid;
    phys_tag_t                       free_tag;

    // Map table side
    phys_tag_t [`DISP_W-1:0]         src1_tag;
    logic [`DISP_W-1:0]              src1_ready;
    phys_tag_t [`DISP_W-1:0]         src2_tag;
    logic [`DISP_W-1:0]              src2_ready;
    phys_tag_t [`DISP_W-1:0]         rd_tag;
    logic [`DISP_W-1:0]              map_wr_en;
    arch_reg_t [`DISP_W-1:0]         map_wr_addr;
    phys_tag_t [`DISP_W-1:0]         map_wr_tag;

    // ROB side
    logic [$clog2(`ROB_DEPTH+1)-1:0] rob_free;
    rob_idx_t                        rob_tail;
    logic [`DISP_W-1:0]              rob_alloc_valid;
    phys_tag_t [`DISP_W-1:0]         rob_prev_tag;

    dispatch_ctrl u_dispatch_ctrl (
        .in_valid        (in_valid),
        .in_category     (in_category),
        .in_rs1          (in_rs1),
        .in_rs2          (in_rs2),
        .in_rd           (in_rd),
        .in_uses_rd      (in_uses_rd),
        .free_count      (free_count),
        .head_tags       (head_tags),
        .rob_free        (rob_free),
        .rob_tail        (rob_tail),
        .src1_tag        (src1_tag),
        .src1_ready      (src1_ready),
        .src2_tag        (src2_tag),
        .src2_ready      (src2_ready),
        .rd_tag          (rd_tag),
        .dispatch_count  (dispatch_count),
        .alloc_count     (alloc_count),
        .map_wr_en       (map_wr_en),
        .map_wr_addr     (map_wr_addr),
        .map_wr_tag      (map_wr_tag),
        .rob_alloc_valid (rob_alloc_valid),
        .rob_prev_tag    (rob_prev_tag),
        .disp_valid      (disp_valid),
        .disp_rob_idx    (disp_rob_idx),
        .disp_dest_tag   (disp_dest_tag),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_ready (disp_src1_ready),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_ready (disp_src2_ready),
        .disp_category   (disp_category)
    );

    map_table u_map_table (
        .clock       (clock),
        .rst_n       (rst_n),
        .rd_addr_a   (in_rs1),
        .rd_addr_b   (in_rs2),
        .rd_addr_d   (in_rd),
        .map_wr_en   (map_wr_en),
        .map_wr_addr (map_wr_addr),
        .map_wr_tag  (map_wr_tag),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .tag_a       (src1_tag),
        .ready_a     (src1_ready),
        .tag_b       (src2_tag),
        .ready_b     (src2_ready),
        .tag_d       (rd_tag)
    );

    free_list u_free_list (
        .clock       (clock),
        .rst_n       (rst_n),
        .alloc_count (alloc_count),
        .free_valid  (free_valid),
        .free_tag    (free_tag),
        .free_count  (free_count),
        .head_tags   (head_tags)
    );

    reorder_buffer u_reorder_buffer (
        .clock           (clock),
        .rst_n           (rst_n),
        .rob_alloc_valid (rob_alloc_valid),
        .alloc_arch_rd   (in_rd),
        .alloc_new_tag   (disp_dest_tag),
        .alloc_prev_tag  (rob_prev_tag),
        .alloc_uses_rd   (in_uses_rd),
        .alloc_category  (in_category),
        .retire          (retire),
        .rob_free        (rob_free),
        .rob_tail        (rob_tail),
        .retire_valid    (retire_valid),
        .retire_arch_rd  (retire_arch_rd),
        .retire_phys_rd  (retire_phys_rd),
        .retire_prev_tag (retire_prev_tag),
        .retire_category (retire_category),
        .free_valid      (free_valid),
        .free_tag        (free_tag)
    );

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
`default_nettype none

`include "rename_params.svh"

module reorder_buffer (
    input  wire logic                                clock,
    input  wire logic                                rst_n,
    input  wire logic [`DISP_W-1:0]                  rob_alloc_valid,
    input  wire rename_pkg::arch_reg_t [`DISP_W-1:0] alloc_arch_rd,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0] alloc_new_tag,
    input  wire rename_pkg::phys_tag_t [`DISP_W-1:0] alloc_prev_tag,
    input  wire logic [`DISP_W-1:0]                  alloc_uses_rd,
    input  wire rename_pkg::op_cat_e [`DISP_W-1:0]   alloc_category,
    input  wire logic                                retire,
    output logic [$clog2(`ROB_DEPTH+1)-1:0]          rob_free,
    output rename_pkg::rob_idx_t                     rob_tail,
    output logic                                     retire_valid,
    output rename_pkg::arch_reg_t                    retire_arch_rd,
    output rename_pkg::phys_tag_t                    retire_phys_rd,
    output rename_pkg::phys_tag_t                    retire_prev_tag,
    output rename_pkg::op_cat_e                      retire_category,
    output logic                                     free_valid,
    output rename_pkg::phys_tag_t                    free_tag
);

    import rename_pkg::*;

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    arch_reg_t             arch_rd_q [`ROB_DEPTH];
    phys_tag_t             phys_rd_q [`ROB_DEPTH];
    phys_tag_t             prev_tag_q [`ROB_DEPTH];
    op_cat_e               category_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] uses_rd_q;
    rob_idx_t              head_q;
    rob_idx_t              tail_q;
    logic [CNT_W-1:0]      count_q;
    logic [CNT_W-1:0]      n_alloc;

    // Valid slots are always a leading run
    assign n_alloc = CNT_W'($countones(rob_alloc_valid));

    always_ff @(posedge clock) begin
        for (int i = 0; i < `DISP_W; i++) begin
            if (rob_alloc_valid[i]) begin
                arch_rd_q[tail_q + rob_idx_t'(i)] <= alloc_arch_rd[i];
                phys_rd_q[tail_q + rob_idx_t'(i)] <= alloc_new_tag[i];
                prev_tag_q[tail_q + rob_idx_t'(i)] <= alloc_prev_tag[i];
                category_q[tail_q + rob_idx_t'(i)] <= alloc_category[i];
                uses_rd_q[tail_q + rob_idx_t'(i)] <= alloc_uses_rd[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            tail_q <= tail_q + rob_idx_t'(n_alloc);
            if (retire_valid) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + n_alloc - CNT_W'(retire_valid);
        end
    end

    // Retire only from a non-empty ROB
    assign retire_valid = retire && (count_q != '0);
    assign retire_arch_rd = arch_rd_q[head_q];
    assign retire_phys_rd = phys_rd_q[head_q];
    assign retire_prev_tag = prev_tag_q[head_q];
    assign retire_category = category_q[head_q];

    // Old mapping goes back to the free list
    assign free_valid = retire_valid && uses_rd_q[head_q];
    assign free_tag = prev_tag_q[head_q];

    assign rob_free = CNT_W'(`ROB_DEPTH) - count_q;
    assign rob_tail = tail_q;

endmodule

`default_nettype wire
